// ==== soc_ifc_pkg.sv ====
`default_nettype none

package soc_ifc_pkg;

    // fuse bank geometry
    localparam int FUSE_WORDS  = 16;
    localparam int FUSE_WORD_W = 32;
    // addr field indexes one fuse word
    localparam int FUSE_ADDR_W = $clog2(FUSE_WORDS);

    // boot sequencing states, shown on the top for observation
    typedef enum logic [2:0] {
        BOOT_IDLE   = 3'd0,
        BOOT_FUSE   = 3'd1,
        BOOT_FW_RST = 3'd2,
        BOOT_WAIT   = 3'd3,
        BOOT_DONE   = 3'd4
    } boot_fsm_state_e;

    // soc command opcodes
    typedef enum logic [1:0] {
        // write one fuse word
        CMD_FUSE_WR    = 2'd0,
        // fuse phase finished, lock the bank
        CMD_FUSE_DONE  = 2'd1,
        // load the update reset wait count from data[7:0]
        CMD_SET_WAIT   = 2'd2,
        // start a firmware update reset of the core
        CMD_FW_UPD_RST = 2'd3
    } boot_cmd_op_e;

    // one soc command, 38 bits
    typedef struct packed {
        boot_cmd_op_e           op;
        logic [FUSE_ADDR_W-1:0] addr;
        logic [FUSE_WORD_W-1:0] data;
    } boot_cmd_t;

    // whole fuse bank, word 0 in the low bits
    typedef logic [FUSE_WORDS-1:0][FUSE_WORD_W-1:0] fuse_bank_t;

endpackage

`default_nettype wire

// ==== soc_ifc_cmd_fifo.sv ====
`default_nettype none

module soc_ifc_cmd_fifo #(
    parameter int DEPTH = 4
) (
    input  logic                   clk,
    input  logic                   cptra_rst_b,
    input  logic                   wr_valid,
    input  soc_ifc_pkg::boot_cmd_t wr_cmd,
    output logic                   pop_valid,
    output soc_ifc_pkg::boot_cmd_t pop_cmd,
    output logic                   credit
);

    import soc_ifc_pkg::*;

    // pointer and occupancy widths
    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);
    localparam logic [PTR_W-1:0] LAST_IDX = PTR_W'(DEPTH - 1);

    // command storage, payload only
    boot_cmd_t mem [DEPTH];

    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;

    // circular increment, depth need not be a power of two
    function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] ptr);
        logic [PTR_W-1:0] nxt;
        nxt = (ptr == LAST_IDX) ? '0 : ptr + 1'b1;
        return nxt;
    endfunction

    // head is handed to the decoder whenever anything is stored
    // decoder always takes it, so non-empty means pop
    assign pop_valid = (count != '0);
    assign pop_cmd   = mem[rd_ptr];

    // sender holds credits, so a write never lands on a full buffer
    always_ff @(posedge clk) begin
        if (wr_valid) begin
            mem[wr_ptr] <= wr_cmd;
        end
    end

    always_ff @(posedge clk or negedge cptra_rst_b) begin
        if (!cptra_rst_b) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
            credit <= 1'b0;
        end
        else begin
            if (wr_valid) begin
                wr_ptr <= next_ptr(wr_ptr);
            end
            if (pop_valid) begin
                rd_ptr <= next_ptr(rd_ptr);
            end
            // occupancy, simultaneous push and pop leaves it unchanged
            unique case ({wr_valid, pop_valid})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
            // one credit back per popped entry, one cycle later
            credit <= pop_valid;
        end
    end

endmodule

`default_nettype wire

// ==== soc_ifc_boot_regs.sv ====
`default_nettype none

module soc_ifc_boot_regs #(
    parameter logic [7:0] DEFAULT_WAIT_CYCLES = 8'd20
) (
    input  logic                    clk,
    input  logic                    cptra_rst_b,
    input  logic                    pop_valid,
    input  soc_ifc_pkg::boot_cmd_t  pop_cmd,
    input  logic                    ready_for_fuses,
    output soc_ifc_pkg::fuse_bank_t fuse_bank,
    output logic                    fuse_done,
    output logic                    fuse_err,
    output logic                    fw_update_rst,
    output logic [7:0]              fw_update_rst_wait_cycles
);

    import soc_ifc_pkg::*;

    // fuses are writable only while the fsm asks for them and before done
    logic fuse_window;

    // per-opcode strobes for the popped command
    logic is_fuse_wr;
    logic is_fuse_done;
    logic is_set_wait;
    logic is_fw_upd_rst;

    // accepted and rejected fuse accesses
    logic fuse_wr_ok;
    logic fuse_done_ok;
    logic fuse_access_bad;

    assign fuse_window = ready_for_fuses && !fuse_done;

    // opcode decode, all gated by the fifo valid
    always_comb begin
        is_fuse_wr    = 1'b0;
        is_fuse_done  = 1'b0;
        is_set_wait   = 1'b0;
        is_fw_upd_rst = 1'b0;
        if (pop_valid) begin
            unique case (pop_cmd.op)
                CMD_FUSE_WR:    is_fuse_wr    = 1'b1;
                CMD_FUSE_DONE:  is_fuse_done  = 1'b1;
                CMD_SET_WAIT:   is_set_wait   = 1'b1;
                CMD_FW_UPD_RST: is_fw_upd_rst = 1'b1;
                default:        is_fuse_wr    = 1'b0;
            endcase
        end
    end

    assign fuse_wr_ok   = is_fuse_wr && fuse_window;
    assign fuse_done_ok = is_fuse_done && fuse_window;
    // fuse write or done outside the fuse phase is dropped and flagged
    assign fuse_access_bad = (is_fuse_wr || is_fuse_done) && !fuse_window;

    // fuse storage, cleared on reset so the bank reads zero before boot
    always_ff @(posedge clk or negedge cptra_rst_b) begin
        if (!cptra_rst_b) begin
            fuse_bank <= '0;
        end
        else if (fuse_wr_ok) begin
            fuse_bank[pop_cmd.addr] <= pop_cmd.data;
        end
    end

    // control flags
    always_ff @(posedge clk or negedge cptra_rst_b) begin
        if (!cptra_rst_b) begin
            fuse_done     <= 1'b0;
            fuse_err      <= 1'b0;
            fw_update_rst <= 1'b0;
        end
        else begin
            // fuse done is sticky, it locks the bank until the next reset
            if (fuse_done_ok) begin
                fuse_done <= 1'b1;
            end
            // sticky error
            if (fuse_access_bad) begin
                fuse_err <= 1'b1;
            end
            // single cycle request, fsm acts on it only in BOOT_DONE
            fw_update_rst <= is_fw_upd_rst;
        end
    end

    // update reset wait count, low byte of data
    always_ff @(posedge clk or negedge cptra_rst_b) begin
        if (!cptra_rst_b) begin
            fw_update_rst_wait_cycles <= DEFAULT_WAIT_CYCLES;
        end
        else if (is_set_wait) begin
            fw_update_rst_wait_cycles <= pop_cmd.data[7:0];
        end
    end

endmodule

`default_nettype wire

// ==== soc_ifc_boot_fsm.sv ====
`default_nettype none

module soc_ifc_boot_fsm (
    input  logic                          clk,
    input  logic                          cptra_pwrgood,
    input  logic                          cptra_rst_b,
    input  logic                          fw_update_rst,
    input  logic [7:0]                    fw_update_rst_wait_cycles,
    input  logic                          fuse_done,
    output logic                          ready_for_fuses,
    output logic                          cptra_noncore_rst_b,
    output logic                          cptra_uc_rst_b,
    output logic                          iccm_unlock,
    output soc_ifc_pkg::boot_fsm_state_e  boot_state
);

    import soc_ifc_pkg::*;

    boot_fsm_state_e state_q;
    boot_fsm_state_e state_d;

    // state transition arcs
    logic arc_idle_fuse;
    logic arc_fuse_done;
    logic arc_done_fwrst;
    logic arc_wait_done;

    // per-state controls
    logic release_en;
    logic uc_hold;
    logic iccm_unlock_d;
    logic wait_count_decr;

    // reset release pipeline
    logic noncore_stage;
    logic uc_stage;

    // update reset timer
    logic [7:0] wait_count;

    // power good from the soc starts the fuse phase
    assign arc_idle_fuse  = cptra_pwrgood;
    // decoder saw fuse done inside the fuse window
    assign arc_fuse_done  = fuse_done;
    // firmware update request, only honoured from BOOT_DONE
    assign arc_done_fwrst = fw_update_rst;
    // timer expired
    assign arc_wait_done  = (wait_count == '0);

    always_comb begin
        state_d         = state_q;
        ready_for_fuses = 1'b0;
        release_en      = 1'b0;
        uc_hold         = 1'b0;
        iccm_unlock_d   = 1'b0;
        wait_count_decr = 1'b0;
        unique case (state_q)
            BOOT_IDLE: begin
                if (arc_idle_fuse) begin
                    state_d = BOOT_FUSE;
                end
            end
            BOOT_FUSE: begin
                // soc may write fuses for every cycle here
                ready_for_fuses = 1'b1;
                if (arc_fuse_done) begin
                    state_d = BOOT_DONE;
                end
            end
            BOOT_FW_RST: begin
                // single cycle, core held and iccm opened for the new image
                uc_hold         = 1'b1;
                iccm_unlock_d   = 1'b1;
                wait_count_decr = 1'b1;
                state_d         = BOOT_WAIT;
            end
            BOOT_WAIT: begin
                uc_hold         = 1'b1;
                wait_count_decr = 1'b1;
                if (arc_wait_done) begin
                    state_d = BOOT_DONE;
                end
            end
            BOOT_DONE: begin
                // let both resets go
                release_en = 1'b1;
                if (arc_done_fwrst) begin
                    state_d = BOOT_FW_RST;
                end
            end
            default: begin
                state_d = BOOT_IDLE;
            end
        endcase
    end

    always_ff @(posedge clk or negedge cptra_rst_b) begin
        if (!cptra_rst_b) begin
            state_q             <= BOOT_IDLE;
            noncore_stage       <= 1'b0;
            uc_stage            <= 1'b0;
            cptra_noncore_rst_b <= 1'b0;
            cptra_uc_rst_b      <= 1'b0;
            iccm_unlock         <= 1'b0;
        end
        else begin
            state_q <= state_d;
            // non-core release is sticky once boot is done
            if (release_en) begin
                noncore_stage <= 1'b1;
            end
            cptra_noncore_rst_b <= noncore_stage;
            // core follows non-core, and drops right away on an update hold
            uc_stage       <= release_en;
            cptra_uc_rst_b <= noncore_stage && uc_stage && !uc_hold;
            iccm_unlock    <= iccm_unlock_d;
        end
    end

    // timer tracks the programmed value while idle
    // it counts down only during the update sequence and stops at zero
    always_ff @(posedge clk or negedge cptra_rst_b) begin
        if (!cptra_rst_b) begin
            wait_count <= '0;
        end
        else if (wait_count_decr) begin
            if (wait_count != '0) begin
                wait_count <= wait_count - 1'b1;
            end
        end
        else begin
            wait_count <= fw_update_rst_wait_cycles;
        end
    end

    assign boot_state = state_q;

endmodule

`default_nettype wire

// ==== soc_ifc_boot_top.sv ====
`default_nettype none

module soc_ifc_boot_top #(
    parameter int         CMD_FIFO_DEPTH      = 4,
    parameter logic [7:0] DEFAULT_WAIT_CYCLES = 8'd20
) (
    input  logic                          clk,
    input  logic                          cptra_rst_b,
    input  logic                          cptra_pwrgood,
    input  logic                          cmd_valid,
    input  soc_ifc_pkg::boot_cmd_t        cmd,
    output logic                          cmd_credit,
    output logic                          ready_for_fuses,
    output logic                          cptra_noncore_rst_b,
    output logic                          cptra_uc_rst_b,
    output logic                          iccm_unlock,
    output soc_ifc_pkg::fuse_bank_t       fuse_bank,
    output logic                          fuse_err,
    output soc_ifc_pkg::boot_fsm_state_e  boot_state
);

    import soc_ifc_pkg::*;

    // fifo head towards the decoder
    logic      pop_valid;
    boot_cmd_t pop_cmd;

    // decoder to fsm
    logic       fuse_done;
    logic       fw_update_rst;
    logic [7:0] fw_update_rst_wait_cycles;

    // credit-flow command buffer
    soc_ifc_cmd_fifo #(
        .DEPTH (CMD_FIFO_DEPTH)
    ) soc_ifc_cmd_fifo_inst (
        .clk         (clk),
        .cptra_rst_b (cptra_rst_b),
        .wr_valid    (cmd_valid),
        .wr_cmd      (cmd),
        .pop_valid   (pop_valid),
        .pop_cmd     (pop_cmd),
        .credit      (cmd_credit)
    );

    // command decode and fuse storage
    soc_ifc_boot_regs #(
        .DEFAULT_WAIT_CYCLES (DEFAULT_WAIT_CYCLES)
    ) soc_ifc_boot_regs_inst (
        .clk                       (clk),
        .cptra_rst_b               (cptra_rst_b),
        .pop_valid                 (pop_valid),
        .pop_cmd                   (pop_cmd),
        .ready_for_fuses           (ready_for_fuses),
        .fuse_bank                 (fuse_bank),
        .fuse_done                 (fuse_done),
        .fuse_err                  (fuse_err),
        .fw_update_rst             (fw_update_rst),
        .fw_update_rst_wait_cycles (fw_update_rst_wait_cycles)
    );

    // boot sequencing and reset generation
    soc_ifc_boot_fsm soc_ifc_boot_fsm_inst (
        .clk                       (clk),
        .cptra_pwrgood             (cptra_pwrgood),
        .cptra_rst_b               (cptra_rst_b),
        .fw_update_rst             (fw_update_rst),
        .fw_update_rst_wait_cycles (fw_update_rst_wait_cycles),
        .fuse_done                 (fuse_done),
        .ready_for_fuses           (ready_for_fuses),
        .cptra_noncore_rst_b       (cptra_noncore_rst_b),
        .cptra_uc_rst_b            (cptra_uc_rst_b),
        .iccm_unlock               (iccm_unlock),
        .boot_state                (boot_state)
    );

endmodule

`default_nettype wire

// ==== soc_ifc_boot_tb.sv ====
`default_nettype none

module soc_ifc_boot_tb;

    timeunit 1ns;
    timeprecision 1ps;

    import soc_ifc_pkg::*;

    localparam int         DEPTH        = 4;
    localparam logic [7:0] DEFAULT_WAIT = 8'd20;
    // cycles any single wait may take
    localparam int         TIMEOUT      = 200;

    logic            clk;
    logic            cptra_rst_b;
    logic            cptra_pwrgood;
    logic            cmd_valid;
    boot_cmd_t       cmd;
    logic            cmd_credit;
    logic            ready_for_fuses;
    logic            cptra_noncore_rst_b;
    logic            cptra_uc_rst_b;
    logic            iccm_unlock;
    fuse_bank_t      fuse_bank;
    logic            fuse_err;
    boot_fsm_state_e boot_state;

    // credits spent by the driver and returned by the DUT
    int              sent;
    int              back;
    // random source
    logic [31:0]     lfsr;
    // reference model
    fuse_bank_t      exp_bank;
    logic            exp_err;
    logic [7:0]      exp_wait;
    boot_fsm_state_e exp_state;
    // non-core reset has been released since the last reset
    logic            noncore_up;
    int              n;

    soc_ifc_boot_top #(
        .CMD_FIFO_DEPTH      (DEPTH),
        .DEFAULT_WAIT_CYCLES (DEFAULT_WAIT)
    ) soc_ifc_boot_top_inst (.*);

    initial clk = 1'b0;
    always #4 clk = ~clk;

    task automatic stop_run(input string why);
        $display("%s", why);
        $display("Finished with errors");
        $fatal(1, "simulation stopped on error");
    endtask

    function automatic int credits_held();
        return DEPTH - sent + back;
    endfunction

    task automatic check_bit(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            stop_run($sformatf("[FAIL] %s: expected %b, actual %b", name, exp, act));
        end
    endtask

    task automatic check_state(input string name, input boot_fsm_state_e exp,
                               input boot_fsm_state_e act);
        if (act !== exp) begin
            stop_run($sformatf("[FAIL] %s: expected %s, actual %s", name, exp.name(), act.name()));
        end
    endtask

    task automatic check_fuse_bank(input string name, input fuse_bank_t exp,
                                   input fuse_bank_t act);
        if (act !== exp) begin
            stop_run($sformatf("[FAIL] %s: expected %h, actual %h", name, exp, act));
        end
    endtask

    // cycle counts checked against a closed range
    task automatic check_count(input string name, input int lo, input int hi, input int act);
        if (act < lo || act > hi) begin
            stop_run($sformatf("[FAIL] %s: expected %0d..%0d, actual %0d", name, lo, hi, act));
        end
    endtask

    // galois lfsr stepped once per bit taken
    function automatic logic [31:0] rand_bits(input int nbits);
        logic [31:0] r;
        int          i;
        r = '0;
        for (i = 0; i < nbits; i++) begin
            r    = {r[30:0], lfsr[0]};
            lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'hB4BC_D35C) : (lfsr >> 1);
        end
        return r;
    endfunction

    function automatic boot_cmd_t make_cmd(input boot_cmd_op_e op, input logic [3:0] addr,
                                           input logic [31:0] data);
        boot_cmd_t c;
        c.op   = op;
        c.addr = addr;
        c.data = data;
        return c;
    endfunction

    // expected bank after one command
    // writes land only inside the fuse window
    function automatic fuse_bank_t ref_bank(input fuse_bank_t bank, input boot_cmd_t c,
                                            input logic window);
        fuse_bank_t nb;
        nb = bank;
        if (c.op == CMD_FUSE_WR && window) begin
            nb[c.addr] = c.data;
        end
        return nb;
    endfunction

    task automatic model_cmd(input boot_cmd_t c);
        logic window;
        window   = (exp_state == BOOT_FUSE);
        exp_bank = ref_bank(exp_bank, c, window);
        // fuse access outside the window is dropped and flagged
        if ((c.op == CMD_FUSE_WR || c.op == CMD_FUSE_DONE) && !window) begin
            exp_err = 1'b1;
        end
        if (c.op == CMD_FUSE_DONE && window) begin
            exp_state = BOOT_DONE;
        end
        if (c.op == CMD_SET_WAIT) begin
            exp_wait = c.data[7:0];
        end
    endtask

    // one command per cycle while credits last
    task automatic send_cmd(input boot_cmd_t c);
        int waited;
        waited = 0;
        while (credits_held() == 0) begin
            cmd_valid = 1'b0;
            @(posedge clk);
            #1;
            waited++;
            if (waited > TIMEOUT) begin
                stop_run("timeout: no command credit came back to the sender");
            end
        end
        cmd_valid = 1'b1;
        cmd       = c;
        sent++;
        model_cmd(c);
        @(posedge clk);
        #1;
        cmd_valid = 1'b0;
    endtask

    task automatic send_fuse_wr();
        boot_cmd_t c;
        c.op   = CMD_FUSE_WR;
        c.addr = 4'(rand_bits(4));
        c.data = rand_bits(32);
        send_cmd(c);
    endtask

    task automatic drain_credits();
        int waited;
        waited = 0;
        while (credits_held() != DEPTH) begin
            @(posedge clk);
            #1;
            waited++;
            if (waited > TIMEOUT) begin
                stop_run("timeout: not all command credits were returned");
            end
        end
    endtask

    task automatic wait_state(input boot_fsm_state_e s);
        int waited;
        waited = 0;
        while (boot_state != s) begin
            @(posedge clk);
            #1;
            waited++;
            if (waited > TIMEOUT) begin
                stop_run($sformatf("timeout: boot_state never reached %s", s.name()));
            end
        end
    endtask

    task automatic wait_release();
        int waited;
        waited = 0;
        while (!(cptra_noncore_rst_b && cptra_uc_rst_b)) begin
            @(posedge clk);
            #1;
            waited++;
            if (waited > TIMEOUT) begin
                stop_run("timeout: non-core and core resets were not both released");
            end
        end
    endtask

    task automatic reset_dut();
        cptra_rst_b   = 1'b0;
        cptra_pwrgood = 1'b0;
        cmd_valid     = 1'b0;
        cmd           = '0;
        sent          = 0;
        exp_bank      = '0;
        exp_err       = 1'b0;
        exp_wait      = DEFAULT_WAIT;
        exp_state     = BOOT_IDLE;
        repeat (16) @(posedge clk);
        #1;
        cptra_rst_b = 1'b1;
    endtask

    // power good, random fuse writes, fuse done, reset release
    task automatic run_fuse_phase(input int writes);
        int waited;
        waited        = 0;
        cptra_pwrgood = 1'b1;
        exp_state     = BOOT_FUSE;
        while (!ready_for_fuses) begin
            @(posedge clk);
            #1;
            waited++;
            if (waited > TIMEOUT) begin
                stop_run("timeout: ready_for_fuses did not rise after cptra_pwrgood");
            end
        end
        check_state("fuse phase entered", exp_state, boot_state);
        repeat (writes) send_fuse_wr();
        drain_credits();
        check_fuse_bank("fuse writes", exp_bank, fuse_bank);
        check_bit("no fuse error in fuse phase", exp_err, fuse_err);
        send_cmd(make_cmd(CMD_FUSE_DONE, 4'd0, 32'd0));
        wait_state(exp_state);
        wait_release();
        check_bit("ready_for_fuses after fuse done", 1'b0, ready_for_fuses);
    endtask

    // core reset low time and iccm strobe width of one update
    task automatic check_update_pulse(input string name, input int lo);
        int waited;
        int low_cycles;
        int unlock_cycles;
        waited        = 0;
        low_cycles    = 0;
        unlock_cycles = 0;
        do begin
            @(negedge clk);
            waited++;
            if (iccm_unlock) begin
                unlock_cycles++;
            end
            if (!cptra_uc_rst_b) begin
                low_cycles++;
            end
            if (waited > 2 * TIMEOUT) begin
                stop_run("timeout: core reset did not complete the update pulse");
            end
        end while (!(cptra_uc_rst_b && low_cycles > 0));
        check_count({name, " core reset low"}, lo, lo + 4, low_cycles);
        check_count({name, " iccm unlock"}, 1, 1, unlock_cycles);
        @(posedge clk);
        #1;
    endtask

    // credit returns and reset invariants on the falling edge
    always @(negedge clk) begin
        if (!cptra_rst_b) begin
            back       = 0;
            noncore_up = 1'b0;
        end
        else begin
            if (cmd_credit) begin
                back++;
            end
            if (credits_held() > DEPTH) begin
                stop_run("more credits came back than commands were sent");
            end
            if (noncore_up && !cptra_noncore_rst_b) begin
                stop_run("cptra_noncore_rst_b dropped after its release");
            end
            if (cptra_noncore_rst_b) begin
                noncore_up = 1'b1;
            end
        end
    end

    initial begin
        lfsr = 32'd51;
        n    = 0;
        reset_dut();
        // reset values before power good
        repeat (4) @(posedge clk);
        #1;
        check_state("state after reset", BOOT_IDLE, boot_state);
        check_bit("noncore reset after reset", 1'b0, cptra_noncore_rst_b);
        check_bit("core reset after reset", 1'b0, cptra_uc_rst_b);
        check_bit("iccm_unlock after reset", 1'b0, iccm_unlock);
        check_bit("ready_for_fuses before pwrgood", 1'b0, ready_for_fuses);
        check_fuse_bank("fuse bank after reset", '0, fuse_bank);
        run_fuse_phase(24);
        // late writes are locked out
        repeat (3) send_fuse_wr();
        drain_credits();
        check_fuse_bank("bank locked after fuse done", exp_bank, fuse_bank);
        check_bit("fuse error after late writes", exp_err, fuse_err);
        // programmed update reset
        n = 2 + int'(rand_bits(6) % 39);
        send_cmd(make_cmd(CMD_SET_WAIT, 4'd0, 32'(n)));
        send_cmd(make_cmd(CMD_FW_UPD_RST, 4'd0, 32'd0));
        check_update_pulse("programmed wait", int'(exp_wait));
        wait_state(BOOT_DONE);
        check_bit("noncore reset after update", 1'b1, cptra_noncore_rst_b);
        // second boot then an update with the reset wait value
        reset_dut();
        run_fuse_phase(8);
        send_cmd(make_cmd(CMD_FW_UPD_RST, 4'd0, 32'd0));
        check_update_pulse("default wait", int'(exp_wait));
        wait_state(BOOT_DONE);
        drain_credits();
        check_bit("fuse error after second boot", exp_err, fuse_err);
        $display("Finished with no errors");
        $finish;
    end

endmodule

`default_nettype wire

// ==== files.f ====
soc_ifc_pkg.sv
soc_ifc_cmd_fifo.sv
soc_ifc_boot_regs.sv
soc_ifc_boot_fsm.sv
soc_ifc_boot_top.sv
soc_ifc_boot_tb.sv

// ==== Makefile ====
SRCS := $(shell cat files.f)

.PHONY: all run clean

all: run

obj_dir/Vsoc_ifc_boot_tb: files.f $(SRCS)
	verilator --binary --timing --timescale 1ns/1ps --top-module soc_ifc_boot_tb -f files.f

run: obj_dir/Vsoc_ifc_boot_tb
	./obj_dir/Vsoc_ifc_boot_tb 2>&1 | tee sim.log
	grep -q "^Finished with no errors$$" sim.log

clean:
	rm -rf obj_dir sim.log
